// File: rtl/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Data path and address width
`define CPU_XLEN 32

// Register file geometry
`define CPU_REG_AW 5
`define CPU_NUM_REGS 32

// First fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

// Sequential fetch increment
`define CPU_PC_STEP 32'd4

`endif

// File: rtl/cpu_pkg.sv
`include "cpu_defines.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0] word_t;
    typedef logic [`CPU_REG_AW-1:0] reg_addr_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LUI    = 7'b0110111,
        OP_JAL    = 7'b1101111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU
    } branch_e;

    typedef enum logic [2:0] {
        ST_IF,
        ST_IW,
        ST_ID,
        ST_EXE,
        ST_WB,
        ST_ST,
        ST_LD,
        ST_RDW
    } state_e;

    typedef struct packed {
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     imm;
        alu_op_e   alu_op;
        logic      use_imm;
        branch_e   branch;
        logic      is_jal;
        logic      is_lui;
        logic      is_load;
        logic      is_store;
        logic      reg_write;
    } ctrl_t;

    typedef struct packed {
        word_t                  addr;
        word_t                  wdata;
        logic [`CPU_XLEN/8-1:0] wstrb;
        logic                   write;
        logic                   read;
    } mem_req_t;

    typedef struct packed {
        logic      valid;
        logic      wen;
        reg_addr_t waddr;
        word_t     wdata;
        word_t     pc;
    } retire_t;

    // Outcome of a - b, used by the branch compare
    typedef struct packed {
        logic zero;
        logic neg_signed;
        logic lt_unsigned;
    } alu_flags_t;

endpackage

// File: rtl/cpu_decoder.sv
module cpu_decoder (
    input  cpu_pkg::word_t instruction,
    output cpu_pkg::ctrl_t ctrl
);

    logic [2:0]       funct3;
    logic             is_reg_op;
    cpu_pkg::word_t   imm_i;
    cpu_pkg::word_t   imm_s;
    cpu_pkg::word_t   imm_b;
    cpu_pkg::word_t   imm_j;
    cpu_pkg::word_t   imm_u;
    cpu_pkg::alu_op_e arith_op;
    cpu_pkg::branch_e branch_kind;

    assign funct3    = instruction[14:12];
    assign is_reg_op = (instruction[6:0] == cpu_pkg::OP_REG);

    assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
    assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign imm_b = {{19{instruction[31]}}, instruction[31], instruction[7],
                    instruction[30:25], instruction[11:8], 1'b0};
    assign imm_j = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                    instruction[20], instruction[30:21], 1'b0};
    assign imm_u = {instruction[31:12], 12'b0};

    // Bit 30 picks SUB and SRA; only R-type uses it for SUB
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (is_reg_op && instruction[30]) ? cpu_pkg::ALU_SUB
                                                                : cpu_pkg::ALU_ADD;
            3'b001:  arith_op = cpu_pkg::ALU_SLL;
            3'b010:  arith_op = cpu_pkg::ALU_SLT;
            3'b011:  arith_op = cpu_pkg::ALU_SLTU;
            3'b100:  arith_op = cpu_pkg::ALU_XOR;
            3'b101:  arith_op = instruction[30] ? cpu_pkg::ALU_SRA : cpu_pkg::ALU_SRL;
            3'b110:  arith_op = cpu_pkg::ALU_OR;
            default: arith_op = cpu_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  branch_kind = cpu_pkg::BR_EQ;
            3'b001:  branch_kind = cpu_pkg::BR_NE;
            3'b100:  branch_kind = cpu_pkg::BR_LT;
            3'b101:  branch_kind = cpu_pkg::BR_GE;
            3'b110:  branch_kind = cpu_pkg::BR_LTU;
            3'b111:  branch_kind = cpu_pkg::BR_GEU;
            default: branch_kind = cpu_pkg::BR_NONE;
        endcase
    end

    always_comb begin
        ctrl        = '0;
        ctrl.rs1    = instruction[19:15];
        ctrl.rs2    = instruction[24:20];
        ctrl.rd     = instruction[11:7];
        ctrl.imm    = imm_i;
        ctrl.alu_op = cpu_pkg::ALU_ADD;
        ctrl.branch = cpu_pkg::BR_NONE;
        case (instruction[6:0])
            cpu_pkg::OP_REG: begin
                ctrl.alu_op    = arith_op;
                ctrl.reg_write = 1'b1;
            end
            cpu_pkg::OP_IMM: begin
                ctrl.alu_op    = arith_op;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            cpu_pkg::OP_LUI: begin
                ctrl.imm       = imm_u;
                ctrl.is_lui    = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            cpu_pkg::OP_JAL: begin
                ctrl.imm       = imm_j;
                ctrl.is_jal    = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            cpu_pkg::OP_BRANCH: begin
                ctrl.imm    = imm_b;
                ctrl.alu_op = cpu_pkg::ALU_SUB;
                ctrl.branch = branch_kind;
            end
            // Only word accesses are supported
            cpu_pkg::OP_LOAD: begin
                if (funct3 == 3'b010) begin
                    ctrl.use_imm   = 1'b1;
                    ctrl.is_load   = 1'b1;
                    ctrl.reg_write = 1'b1;
                end
            end
            cpu_pkg::OP_STORE: begin
                if (funct3 == 3'b010) begin
                    ctrl.imm      = imm_s;
                    ctrl.use_imm  = 1'b1;
                    ctrl.is_store = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

// File: rtl/cpu_alu.sv
`include "cpu_defines.svh"

module cpu_alu (
    input  cpu_pkg::word_t      a,
    input  cpu_pkg::word_t      b,
    input  cpu_pkg::alu_op_e    op,
    output cpu_pkg::word_t      result,
    output cpu_pkg::alu_flags_t flags
);

    logic [`CPU_XLEN:0] diff;
    logic               overflow;
    logic [4:0]         shamt;

    // Extra top bit holds the borrow
    assign diff     = {1'b0, a} - {1'b0, b};
    assign overflow = (a[`CPU_XLEN-1] ^ b[`CPU_XLEN-1]) & (a[`CPU_XLEN-1] ^ diff[`CPU_XLEN-1]);
    assign shamt    = b[4:0];

    assign flags.zero        = (diff[`CPU_XLEN-1:0] == '0);
    assign flags.neg_signed  = diff[`CPU_XLEN-1] ^ overflow;
    assign flags.lt_unsigned = diff[`CPU_XLEN];

    always_comb begin
        case (op)
            cpu_pkg::ALU_ADD:  result = a + b;
            cpu_pkg::ALU_SUB:  result = diff[`CPU_XLEN-1:0];
            cpu_pkg::ALU_AND:  result = a & b;
            cpu_pkg::ALU_OR:   result = a | b;
            cpu_pkg::ALU_XOR:  result = a ^ b;
            cpu_pkg::ALU_SLT:  result = {{(`CPU_XLEN-1){1'b0}}, flags.neg_signed};
            cpu_pkg::ALU_SLTU: result = {{(`CPU_XLEN-1){1'b0}}, flags.lt_unsigned};
            cpu_pkg::ALU_SLL:  result = a << shamt;
            cpu_pkg::ALU_SRL:  result = a >> shamt;
            cpu_pkg::ALU_SRA:  result = $signed(a) >>> shamt;
            default:           result = '0;
        endcase
    end

endmodule

// File: rtl/cpu_regfile.sv
`include "cpu_defines.svh"

module cpu_regfile (
    input  logic               clk,
    input  cpu_pkg::reg_addr_t raddr1,
    input  cpu_pkg::reg_addr_t raddr2,
    output cpu_pkg::word_t     rdata1,
    output cpu_pkg::word_t     rdata2,
    input  logic               wen,
    input  cpu_pkg::reg_addr_t waddr,
    input  cpu_pkg::word_t     wdata
);

    cpu_pkg::word_t regs [`CPU_NUM_REGS];

    always_ff @(posedge clk) begin
        if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads as zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    a_x0_stays_zero: assert property (@(posedge clk)
        (wen && waddr == '0) |=> (raddr1 != '0 || rdata1 == '0) &&
                                 (raddr2 != '0 || rdata2 == '0));

endmodule

// File: rtl/cpu_control.sv
`include "cpu_defines.svh"

module cpu_control (
    input  logic                clk,
    input  logic                rst,
    input  logic                inst_req_ready,
    input  logic                inst_valid,
    input  cpu_pkg::word_t      instruction,
    output cpu_pkg::word_t      pc,
    output logic                inst_req_valid,
    output logic                inst_ready,
    output cpu_pkg::word_t      inst_word,
    input  cpu_pkg::ctrl_t      ctrl,
    input  cpu_pkg::word_t      rdata1,
    input  cpu_pkg::word_t      rdata2,
    output cpu_pkg::word_t      alu_a,
    output cpu_pkg::word_t      alu_b,
    output cpu_pkg::alu_op_e    alu_op,
    input  cpu_pkg::word_t      alu_result,
    input  cpu_pkg::alu_flags_t alu_flags,
    output logic                rf_wen,
    output cpu_pkg::reg_addr_t  rf_waddr,
    output cpu_pkg::word_t      rf_wdata,
    output cpu_pkg::mem_req_t   mem_req,
    input  logic                mem_req_ready,
    input  cpu_pkg::word_t      read_data,
    input  logic                read_data_valid,
    output logic                read_data_ready,
    output cpu_pkg::retire_t    retire
);

    cpu_pkg::state_e state_q;
    cpu_pkg::state_e state_d;
    cpu_pkg::word_t  pc_q;
    logic            req_valid_q;
    cpu_pkg::word_t  inst_q;
    cpu_pkg::word_t  inst_pc_q;
    cpu_pkg::ctrl_t  ctrl_q;
    cpu_pkg::word_t  op1_q;
    cpu_pkg::word_t  op2_q;
    cpu_pkg::word_t  res_q;
    cpu_pkg::word_t  load_q;
    logic            taken;
    logic            redirect;

    always_comb begin
        case (ctrl_q.branch)
            cpu_pkg::BR_EQ:  taken = alu_flags.zero;
            cpu_pkg::BR_NE:  taken = !alu_flags.zero;
            cpu_pkg::BR_LT:  taken = alu_flags.neg_signed;
            cpu_pkg::BR_GE:  taken = !alu_flags.neg_signed;
            cpu_pkg::BR_LTU: taken = alu_flags.lt_unsigned;
            cpu_pkg::BR_GEU: taken = !alu_flags.lt_unsigned;
            default:         taken = 1'b0;
        endcase
    end

    assign redirect = taken || ctrl_q.is_jal;

    always_comb begin
        state_d = state_q;
        case (state_q)
            cpu_pkg::ST_IF:  if (inst_req_valid && inst_req_ready) state_d = cpu_pkg::ST_IW;
            cpu_pkg::ST_IW:  if (inst_valid) state_d = cpu_pkg::ST_ID;
            cpu_pkg::ST_ID:  state_d = cpu_pkg::ST_EXE;
            cpu_pkg::ST_EXE: begin
                if (ctrl_q.is_store) begin
                    state_d = cpu_pkg::ST_ST;
                end else if (ctrl_q.is_load) begin
                    state_d = cpu_pkg::ST_LD;
                end else if (ctrl_q.reg_write) begin
                    state_d = cpu_pkg::ST_WB;
                end else begin
                    state_d = cpu_pkg::ST_IF;
                end
            end
            cpu_pkg::ST_ST:  if (mem_req_ready) state_d = cpu_pkg::ST_IF;
            cpu_pkg::ST_LD:  if (mem_req_ready) state_d = cpu_pkg::ST_RDW;
            cpu_pkg::ST_RDW: if (read_data_valid) state_d = cpu_pkg::ST_WB;
            default:         state_d = cpu_pkg::ST_IF;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= cpu_pkg::ST_IF;
            pc_q        <= `CPU_RESET_PC;
            req_valid_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            req_valid_q <= (state_d == cpu_pkg::ST_IF);
            if (inst_req_valid && inst_req_ready) begin
                pc_q <= pc_q + `CPU_PC_STEP;
            end else if (state_q == cpu_pkg::ST_EXE && redirect) begin
                // Target is relative to the fetched PC
                pc_q <= inst_pc_q + ctrl_q.imm;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == cpu_pkg::ST_IW && inst_valid) begin
            inst_q    <= instruction;
            inst_pc_q <= pc_q - `CPU_PC_STEP;
        end
        if (state_q == cpu_pkg::ST_ID) begin
            ctrl_q <= ctrl;
            op1_q  <= rdata1;
            op2_q  <= rdata2;
        end
        if (state_q == cpu_pkg::ST_EXE) begin
            res_q <= alu_result;
        end
        if (state_q == cpu_pkg::ST_RDW && read_data_valid) begin
            load_q <= read_data;
        end
    end

    assign pc              = pc_q;
    assign inst_req_valid  = req_valid_q;
    assign inst_ready      = (state_q == cpu_pkg::ST_IW);
    assign inst_word       = inst_q;
    assign read_data_ready = (state_q == cpu_pkg::ST_RDW);

    assign alu_a  = op1_q;
    assign alu_b  = ctrl_q.use_imm ? ctrl_q.imm : op2_q;
    assign alu_op = ctrl_q.alu_op;

    // Address was computed by the ALU in EXE
    assign mem_req.addr  = {res_q[`CPU_XLEN-1:2], 2'b00};
    assign mem_req.wdata = op2_q;
    assign mem_req.wstrb = '1;
    assign mem_req.write = (state_q == cpu_pkg::ST_ST);
    assign mem_req.read  = (state_q == cpu_pkg::ST_LD);

    always_comb begin
        if (ctrl_q.is_lui) begin
            rf_wdata = ctrl_q.imm;
        end else if (ctrl_q.is_jal) begin
            rf_wdata = inst_pc_q + `CPU_PC_STEP;
        end else if (ctrl_q.is_load) begin
            rf_wdata = load_q;
        end else begin
            rf_wdata = res_q;
        end
    end

    assign rf_wen   = (state_q == cpu_pkg::ST_WB) && ctrl_q.reg_write;
    assign rf_waddr = ctrl_q.rd;

    assign retire.valid = (state_q == cpu_pkg::ST_WB) ||
                          (state_q == cpu_pkg::ST_EXE && state_d == cpu_pkg::ST_IF) ||
                          (state_q == cpu_pkg::ST_ST && mem_req_ready);
    assign retire.wen   = rf_wen;
    assign retire.waddr = rf_waddr;
    assign retire.wdata = rf_wdata;
    assign retire.pc    = inst_pc_q;

    a_mem_rw_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(mem_req.read && mem_req.write));

    a_fetch_req_held: assert property (@(posedge clk) disable iff (rst)
        (inst_req_valid && !inst_req_ready) |=> inst_req_valid && $stable(pc));

endmodule

// File: rtl/cpu_core.sv
module cpu_core (
    input  logic              clk,
    input  logic              rst,
    output cpu_pkg::word_t    pc,
    output logic              inst_req_valid,
    input  logic              inst_req_ready,
    input  cpu_pkg::word_t    instruction,
    input  logic              inst_valid,
    output logic              inst_ready,
    output cpu_pkg::mem_req_t mem_req,
    input  logic              mem_req_ready,
    input  cpu_pkg::word_t    read_data,
    input  logic              read_data_valid,
    output logic              read_data_ready,
    output cpu_pkg::retire_t  retire
);

    cpu_pkg::word_t      inst_word;
    cpu_pkg::ctrl_t      ctrl;
    cpu_pkg::word_t      rdata1;
    cpu_pkg::word_t      rdata2;
    cpu_pkg::word_t      alu_a;
    cpu_pkg::word_t      alu_b;
    cpu_pkg::alu_op_e    alu_op;
    cpu_pkg::word_t      alu_result;
    cpu_pkg::alu_flags_t alu_flags;
    logic                rf_wen;
    cpu_pkg::reg_addr_t  rf_waddr;
    cpu_pkg::word_t      rf_wdata;

    cpu_control u_control (
        .clk             (clk),
        .rst             (rst),
        .inst_req_ready  (inst_req_ready),
        .inst_valid      (inst_valid),
        .instruction     (instruction),
        .pc              (pc),
        .inst_req_valid  (inst_req_valid),
        .inst_ready      (inst_ready),
        .inst_word       (inst_word),
        .ctrl            (ctrl),
        .rdata1          (rdata1),
        .rdata2          (rdata2),
        .alu_a           (alu_a),
        .alu_b           (alu_b),
        .alu_op          (alu_op),
        .alu_result      (alu_result),
        .alu_flags       (alu_flags),
        .rf_wen          (rf_wen),
        .rf_waddr        (rf_waddr),
        .rf_wdata        (rf_wdata),
        .mem_req         (mem_req),
        .mem_req_ready   (mem_req_ready),
        .read_data       (read_data),
        .read_data_valid (read_data_valid),
        .read_data_ready (read_data_ready),
        .retire          (retire)
    );

    cpu_decoder u_decoder (
        .instruction (inst_word),
        .ctrl        (ctrl)
    );

    // Read addresses come straight from the decoded fields
    cpu_regfile u_regfile (
        .clk    (clk),
        .raddr1 (ctrl.rs1),
        .raddr2 (ctrl.rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wen    (rf_wen),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    cpu_alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result),
        .flags  (alu_flags)
    );

endmodule

// File: tests/cpu_checker.sv
`include "cpu_defines.svh"

module cpu_checker (
    input logic               clk,
    input logic               rst,
    input logic               inst_req_valid,
    input cpu_pkg::word_t     pc,
    input cpu_pkg::mem_req_t  mem_req,
    input logic               mem_req_ready,
    input cpu_pkg::retire_t   retire
);

    cpu_pkg::word_t     exp_pc [64];
    logic               exp_wen [64];
    cpu_pkg::reg_addr_t exp_rd [64];
    cpu_pkg::word_t     exp_value [64];
    cpu_pkg::word_t     exp_st_addr [16];
    cpu_pkg::word_t     exp_st_data [16];
    int                 n_rows = 0;
    int                 next_row = 0;
    int                 n_stores = 0;
    int                 next_store = 0;
    int                 pass_count = 0;
    int                 fail_count = 0;
    logic               first_fetch_seen = 1'b0;
    logic               test_ok;

    task automatic expect_row(input cpu_pkg::word_t rpc, input logic wen,
                              input cpu_pkg::reg_addr_t rd, input cpu_pkg::word_t value);
        exp_pc[n_rows]    = rpc;
        exp_wen[n_rows]   = wen;
        exp_rd[n_rows]    = rd;
        exp_value[n_rows] = value;
        n_rows++;
    endtask

    task automatic expect_store(input cpu_pkg::word_t addr, input cpu_pkg::word_t data);
        exp_st_addr[n_stores] = addr;
        exp_st_data[n_stores] = data;
        n_stores++;
    endtask

    task automatic compare(input string name, input cpu_pkg::word_t exp, input cpu_pkg::word_t act);
        if (exp !== act) begin
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
            test_ok = 1'b0;
        end
    endtask

    task automatic close_test(input string what);
        if (test_ok) begin
            $display("PASS %s", what);
            pass_count++;
        end else begin
            fail_count++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            // First request after reset
            if (!first_fetch_seen && inst_req_valid) begin
                first_fetch_seen = 1'b1;
                test_ok = 1'b1;
                compare("pc", `CPU_RESET_PC, pc);
                compare("mem_req.read", 0, mem_req.read);
                compare("mem_req.write", 0, mem_req.write);
                close_test("reset state");
            end
            if (mem_req.write && mem_req_ready) begin
                test_ok = 1'b1;
                if (next_store < n_stores) begin
                    compare("mem_req.addr", exp_st_addr[next_store], mem_req.addr);
                    compare("mem_req.wdata", exp_st_data[next_store], mem_req.wdata);
                    compare("mem_req.wstrb", 32'hF, {28'b0, mem_req.wstrb});
                end else begin
                    $display("Unexpected store to address %h", mem_req.addr);
                    test_ok = 1'b0;
                end
                close_test($sformatf("store %0d", next_store));
                next_store++;
            end
            // Retires past the end of the table are the idle loop
            if (retire.valid && next_row < n_rows) begin
                test_ok = 1'b1;
                compare("retire.pc", exp_pc[next_row], retire.pc);
                compare("retire.wen", exp_wen[next_row], retire.wen);
                if (exp_wen[next_row]) begin
                    compare("retire.waddr", exp_rd[next_row], retire.waddr);
                    compare("retire.wdata", exp_value[next_row], retire.wdata);
                end
                close_test($sformatf("instruction %0d at pc %h", next_row, exp_pc[next_row]));
                next_row++;
            end
        end
    end

endmodule

// File: tests/tb_cpu_core.sv
module tb_cpu_core;

    typedef struct packed {
        cpu_pkg::word_t     inst;
        cpu_pkg::word_t     pc;
        logic               wen;
        cpu_pkg::reg_addr_t rd;
        cpu_pkg::word_t     value;
        logic               is_store;
        cpu_pkg::word_t     st_addr;
        cpu_pkg::word_t     st_data;
    } test_row_t;

    logic              clk;
    logic              rst;
    cpu_pkg::word_t    pc;
    logic              inst_req_valid;
    logic              inst_req_ready;
    cpu_pkg::word_t    instruction;
    logic              inst_valid;
    logic              inst_ready;
    cpu_pkg::mem_req_t mem_req;
    logic              mem_req_ready;
    cpu_pkg::word_t    read_data;
    logic              read_data_valid;
    logic              read_data_ready;
    cpu_pkg::retire_t  retire;

    cpu_pkg::word_t program_mem [256];
    cpu_pkg::word_t data_mem [256];
    test_row_t      rows [64];
    int             n_rows = 0;
    int             model_errors = 0;
    integer         seed = 32'h03ff_8948;

    cpu_core u_dut (
        .clk             (clk),
        .rst             (rst),
        .pc              (pc),
        .inst_req_valid  (inst_req_valid),
        .inst_req_ready  (inst_req_ready),
        .instruction     (instruction),
        .inst_valid      (inst_valid),
        .inst_ready      (inst_ready),
        .mem_req         (mem_req),
        .mem_req_ready   (mem_req_ready),
        .read_data       (read_data),
        .read_data_valid (read_data_valid),
        .read_data_ready (read_data_ready),
        .retire          (retire)
    );

    cpu_checker u_checker (
        .clk            (clk),
        .rst            (rst),
        .inst_req_valid (inst_req_valid),
        .pc             (pc),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .retire         (retire)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int rand_delay();
        return $unsigned($random(seed)) % 4;
    endfunction

    // RV32I instruction encoders
    function automatic cpu_pkg::word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic cpu_pkg::word_t enc_i(input logic [6:0] op, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic cpu_pkg::word_t enc_sw(input logic [4:0] rs1, input logic [4:0] rs2,
                                              input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic cpu_pkg::word_t enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                             input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic cpu_pkg::word_t enc_jal(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6F};
    endfunction

    task automatic add_row(input cpu_pkg::word_t inst, input cpu_pkg::word_t rpc,
                           input logic wen, input logic [4:0] rd, input cpu_pkg::word_t value);
        rows[n_rows] = '{inst, rpc, wen, rd, value, 1'b0, 32'h0, 32'h0};
        n_rows++;
    endtask

    task automatic add_store(input cpu_pkg::word_t inst, input cpu_pkg::word_t rpc,
                             input cpu_pkg::word_t addr, input cpu_pkg::word_t data);
        rows[n_rows] = '{inst, rpc, 1'b0, 5'd0, 32'h0, 1'b1, addr, data};
        n_rows++;
    endtask

    task automatic build_table();
        // x1 = -8, x2 = 5 feed most of the later rows
        add_row(enc_i(7'h13, 0, 1, 0, 12'hFF8), 0, 1, 1, 32'hFFFF_FFF8);
        add_row(enc_i(7'h13, 0, 2, 0, 12'h005), 4, 1, 2, 32'h0000_0005);
        add_row(enc_r(7'h00, 0, 3, 1, 2), 8, 1, 3, 32'hFFFF_FFFD);
        add_row(enc_r(7'h20, 0, 4, 2, 1), 12, 1, 4, 32'h0000_000D);
        add_row(enc_r(7'h00, 7, 5, 3, 2), 16, 1, 5, 32'h0000_0005);
        add_row(enc_r(7'h00, 6, 6, 1, 2), 20, 1, 6, 32'hFFFF_FFFD);
        add_row(enc_r(7'h00, 4, 7, 1, 2), 24, 1, 7, 32'hFFFF_FFFD);
        add_row(enc_r(7'h00, 2, 8, 1, 2), 28, 1, 8, 32'h0000_0001);
        add_row(enc_r(7'h00, 3, 9, 1, 2), 32, 1, 9, 32'h0000_0000);
        add_row(enc_i(7'h13, 7, 10, 1, 12'h0FF), 36, 1, 10, 32'h0000_00F8);
        add_row(enc_i(7'h13, 6, 11, 2, 12'h030), 40, 1, 11, 32'h0000_0035);
        add_row(enc_i(7'h13, 4, 12, 1, 12'hFFF), 44, 1, 12, 32'h0000_0007);
        add_row(enc_i(7'h13, 2, 13, 1, 12'hFF9), 48, 1, 13, 32'h0000_0001);
        add_row(enc_i(7'h13, 3, 14, 2, 12'hFFF), 52, 1, 14, 32'h0000_0001);
        // x0 write retires with its value but does not stick
        add_row(enc_i(7'h13, 0, 0, 2, 12'h007), 56, 1, 0, 32'h0000_000C);
        add_row(enc_r(7'h00, 0, 15, 0, 2), 60, 1, 15, 32'h0000_0005);
        add_row(enc_r(7'h00, 1, 16, 1, 2), 64, 1, 16, 32'hFFFF_FF00);
        add_row(enc_r(7'h00, 5, 17, 1, 2), 68, 1, 17, 32'h07FF_FFFF);
        add_row(enc_r(7'h20, 5, 18, 1, 2), 72, 1, 18, 32'hFFFF_FFFF);
        add_row(enc_i(7'h13, 1, 19, 1, 12'h004), 76, 1, 19, 32'hFFFF_FF80);
        add_row(enc_i(7'h13, 5, 20, 1, 12'h01C), 80, 1, 20, 32'h0000_000F);
        add_row(enc_i(7'h13, 5, 21, 1, 12'h402), 84, 1, 21, 32'hFFFF_FFFE);
        add_row({20'hABCDE, 5'd22, 7'h37}, 88, 1, 22, 32'hABCD_E000);
        // Taken branches skip one slot, which holds the idle loop
        add_row(enc_b(0, 2, 2, 13'd8), 92, 0, 0, 0);
        add_row(enc_b(0, 1, 2, 13'd8), 100, 0, 0, 0);
        add_row(enc_b(1, 1, 2, 13'd8), 104, 0, 0, 0);
        add_row(enc_b(1, 2, 15, 13'd8), 112, 0, 0, 0);
        add_row(enc_b(4, 1, 2, 13'd8), 116, 0, 0, 0);
        add_row(enc_b(4, 2, 1, 13'd8), 124, 0, 0, 0);
        add_row(enc_b(5, 2, 1, 13'd8), 128, 0, 0, 0);
        add_row(enc_b(5, 1, 2, 13'd8), 136, 0, 0, 0);
        add_row(enc_b(6, 2, 1, 13'd8), 140, 0, 0, 0);
        add_row(enc_b(6, 1, 2, 13'd8), 148, 0, 0, 0);
        add_row(enc_b(7, 1, 2, 13'd8), 152, 0, 0, 0);
        add_row(enc_b(7, 2, 1, 13'd8), 160, 0, 0, 0);
        add_row(enc_jal(23, 21'd12), 164, 1, 23, 32'h0000_00A8);
        add_row(enc_i(7'h13, 0, 24, 0, 12'h100), 176, 1, 24, 32'h0000_0100);
        add_store(enc_sw(24, 3, 12'h004), 180, 32'h0000_0104, 32'hFFFF_FFFD);
        add_row(enc_i(7'h03, 2, 25, 24, 12'h004), 184, 1, 25, 32'hFFFF_FFFD);
        // Unaligned offset lands on the same word
        add_store(enc_sw(24, 2, 12'h006), 188, 32'h0000_0104, 32'h0000_0005);
        add_row(enc_i(7'h03, 2, 26, 24, 12'h004), 192, 1, 26, 32'h0000_0005);
        add_row(enc_r(7'h00, 0, 27, 25, 26), 196, 1, 27, 32'h0000_0002);
    endtask

    // Instruction side
    initial begin : fetch_model
        cpu_pkg::word_t fetch_addr;
        int             t;
        forever begin
            @(negedge clk);
            if (!rst && inst_req_valid) begin
                repeat (rand_delay()) @(negedge clk);
                fetch_addr = pc;
                inst_req_ready = 1'b1;
                @(negedge clk);
                inst_req_ready = 1'b0;
                for (t = 0; t < 50 && !inst_ready; t++) @(negedge clk);
                if (!inst_ready) begin
                    $display("Core never became ready for the fetch at %h", fetch_addr);
                    model_errors++;
                end else begin
                    repeat (rand_delay()) @(negedge clk);
                    instruction = program_mem[fetch_addr[9:2]];
                    inst_valid = 1'b1;
                    @(negedge clk);
                    inst_valid = 1'b0;
                end
            end
        end
    end

    // Data side
    initial begin : data_model
        cpu_pkg::word_t addr;
        logic           is_read;
        int             t;
        forever begin
            @(negedge clk);
            if (!rst && (mem_req.read || mem_req.write)) begin
                repeat (rand_delay()) @(negedge clk);
                addr = mem_req.addr;
                is_read = mem_req.read;
                if (mem_req.write) begin
                    data_mem[addr[9:2]] = mem_req.wdata;
                end
                mem_req_ready = 1'b1;
                @(negedge clk);
                mem_req_ready = 1'b0;
                if (is_read) begin
                    for (t = 0; t < 50 && !read_data_ready; t++) @(negedge clk);
                    if (!read_data_ready) begin
                        $display("Core never became ready for load data from %h", addr);
                        model_errors++;
                    end else begin
                        repeat (rand_delay()) @(negedge clk);
                        read_data = data_mem[addr[9:2]];
                        read_data_valid = 1'b1;
                        @(negedge clk);
                        read_data_valid = 1'b0;
                    end
                end
            end
        end
    end

    initial begin : main
        int  i;
        int  t;
        logic timed_out;
        rst = 1'b1;
        inst_req_ready = 1'b0;
        instruction = '0;
        inst_valid = 1'b0;
        mem_req_ready = 1'b0;
        read_data = '0;
        read_data_valid = 1'b0;
        timed_out = 1'b0;
        // Unused slots hold JAL x0, 0
        for (i = 0; i < 256; i++) begin
            program_mem[i] = 32'h0000_006F;
            data_mem[i] = 32'h5A00_0000 ^ (i * 4);
        end
        build_table();
        for (i = 0; i < n_rows; i++) begin
            program_mem[rows[i].pc[9:2]] = rows[i].inst;
            u_checker.expect_row(rows[i].pc, rows[i].wen, rows[i].rd, rows[i].value);
            if (rows[i].is_store) begin
                u_checker.expect_store(rows[i].st_addr, rows[i].st_data);
            end
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (i = 0; i < n_rows && !timed_out; i++) begin
            for (t = 0; t < 200 && u_checker.next_row <= i; t++) @(negedge clk);
            if (u_checker.next_row <= i) begin
                $display("Timeout: instruction %0d at pc %h never retired", i, rows[i].pc);
                timed_out = 1'b1;
            end
        end
        repeat (2) @(negedge clk);
        if (u_checker.next_store != u_checker.n_stores) begin
            $display("Saw %0d stores where %0d were expected",
                     u_checker.next_store, u_checker.n_stores);
        end
        $display("Tests passed %0d, failed %0d", u_checker.pass_count, u_checker.fail_count);
        if (!timed_out && u_checker.fail_count == 0 && model_errors == 0 &&
            u_checker.next_store == u_checker.n_stores) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: cpu_core.f
+incdir+rtl
rtl/cpu_pkg.sv
rtl/cpu_decoder.sv
rtl/cpu_alu.sv
rtl/cpu_regfile.sv
rtl/cpu_control.sv
rtl/cpu_core.sv
tests/cpu_checker.sv
tests/tb_cpu_core.sv

// File: Bender.yml
package:
  name: cpu_core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cpu_pkg.sv
      - rtl/cpu_decoder.sv
      - rtl/cpu_alu.sv
      - rtl/cpu_regfile.sv
      - rtl/cpu_control.sv
      - rtl/cpu_core.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/cpu_checker.sv
      - tests/tb_cpu_core.sv
